//--- logic/ipcpTypesPkg.sv
package ipcpTypesPkg;

    typedef logic [31:0]       ipT;
    typedef logic [31:0]       byteAddrT;
    typedef logic [26:0]       lineAddrT;   // Byte address bits 31:5
    typedef logic signed [7:0] strideT;     // In lines
    typedef logic [1:0]        confT;

    typedef enum logic [1:0]
    {
        NL   = 2'd0,
        CS   = 2'd1,
        CPLX = 2'd2,
        GS   = 2'd3
    } prefetchClassT;

    typedef struct packed
    {
        logic     valid;
        ipT       ip;
        byteAddrT addr;
    } accessT;

    // Classifier verdict for one access
    typedef struct packed
    {
        logic          valid;
        prefetchClassT cls;
        lineAddrT      base;
        strideT        stride;
    } classResultT;

    typedef struct packed
    {
        logic     valid;
        lineAddrT line;
    } prefetchReqT;

endpackage

//--- logic/ipcpBusPkg.sv
package ipcpBusPkg;

    typedef logic [31:0] wbAddrT;

    // Wishbone classic, read only
    typedef struct packed
    {
        logic   cyc;
        logic   stb;
        logic   we;
        wbAddrT adr;
    } wbMasterT;

    typedef struct packed
    {
        logic ack;
    } wbSlaveT;

endpackage

//--- logic/tableRam.sv
module tableRam #(
    parameter int DataWidth = 8,
    parameter int AddrWidth = 4
) (
    input  logic                 clk,
    input  logic [AddrWidth-1:0] raddr,
    input  logic [AddrWidth-1:0] waddr,
    input  logic [DataWidth-1:0] din,
    input  logic                 we,
    output logic [DataWidth-1:0] dout
);

    logic [DataWidth-1:0] mem [2**AddrWidth];

    // Power-up contents
    initial
    begin
        for (int i = 0; i < 2**AddrWidth; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= din;
        dout <= mem[raddr];     // Old data on collision
    end

endmodule

//--- logic/ipClassifier.sv
module ipClassifier (
    input  logic                      clk,
    input  logic                      RST_vout,
    input  ipcpTypesPkg::accessT      access,
    output ipcpTypesPkg::classResultT classResult
);
    import ipcpTypesPkg::*;

    typedef struct packed
    {
        logic [8:0] tag;
        logic       valid;
        logic [8:0] lastLine;   // Line bits 13:5
        strideT     stride;
        confT       conf;
        logic       stream;     // Riding a trained region
        logic       tentative;
        logic       dir;        // High for descending
    } ipEntryT;

    typedef struct packed
    {
        logic [9:0]  tag;
        logic [5:0]  hits;
        logic [5:0]  lastOff;
        logic [63:0] touched;
        logic [5:0]  posNeg;    // Direction counter, midpoint 32
        logic [5:0]  dense;
        logic        trained;
        logic        dir;
    } regionEntryT;

    typedef struct packed
    {
        strideT stride;
        confT   conf;
    } csptEntryT;

    logic          valid0, valid1;
    ipT            ip0;
    byteAddrT      addr0;
    logic [5:0]    offset0;
    ipEntryT       ipRd, ipWr;
    regionEntryT   regRd, regWr;
    csptEntryT     csptRd, csptWr;
    logic [6:0]    sigRd, sigWr, sig1;
    logic [6:0]    csptRaddr;
    logic [5:0]    ipIdx1;
    logic          ipHit, regionHit, csptWe;
    prefetchClassT cls0, cls1, cls2;
    strideT        delta, stride0, stride1, stride2;
    lineAddrT      line1;

    tableRam #(.DataWidth(32), .AddrWidth(6)) ipTable (
        .clk(clk), .raddr(access.ip[7:2]), .waddr(ip0[7:2]),
        .din(ipWr), .we(valid0), .dout(ipRd));

    tableRam #(.DataWidth(7), .AddrWidth(6)) sigTable (
        .clk(clk), .raddr(access.ip[7:2]), .waddr(ipIdx1),
        .din(sigWr), .we(csptWe), .dout(sigRd));

    tableRam #(.DataWidth(100), .AddrWidth(4)) regionTable (
        .clk(clk), .raddr(access.addr[14:11]), .waddr(addr0[14:11]),
        .din(regWr), .we(valid0), .dout(regRd));

    tableRam #(.DataWidth(10), .AddrWidth(7)) csptTable (
        .clk(clk), .raddr(csptRaddr), .waddr(sig1),
        .din(csptWr), .we(csptWe), .dout(csptRd));

    assign offset0   = addr0[10:5];
    assign ipHit     = ipRd.tag == ip0[16:8];
    assign regionHit = regRd.tag == addr0[24:15];

    // Stage two writes the same signature entry this cycle
    assign sigWr     = {sig1[5:0], 1'b0} ^ stride1[6:0];
    assign csptWe    = valid1 && cls1 == CPLX;
    assign csptRaddr = (csptWe && ipIdx1 == ip0[7:2]) ? sigWr : sigRd;

    always_comb
    begin
        regWr = regRd;
        if (!regionHit)
        begin
            if (regRd.hits == '0)
            begin
                regWr         = '0;
                regWr.tag     = addr0[24:15];
                regWr.lastOff = offset0;
                regWr.posNeg  = 6'd32;
                regWr.dir     = 1'b1;
            end
            else
                regWr.hits = regRd.hits - 1'b1;   // Age out the old owner
        end
        else
        begin
            if (regRd.hits != 6'h3f)
                regWr.hits = regRd.hits + 1'b1;
            regWr.lastOff = offset0;
            regWr.touched = regRd.touched | (64'd1 << offset0);
            if (regRd.posNeg != '0 && offset0 < regRd.lastOff)
                regWr.posNeg = regRd.posNeg - 1'b1;
            else if (regRd.posNeg != 6'h3f && offset0 > regRd.lastOff)
                regWr.posNeg = regRd.posNeg + 1'b1;
            if (!regRd.touched[offset0])
                regWr.dense = regRd.dense + 1'b1;
            regWr.trained = regRd.trained | (&regRd.dense[5:4]);
            regWr.dir     = ~regWr.posNeg[5];
        end
    end

    always_comb
    begin
        ipWr    = ipRd;
        cls0    = NL;
        delta   = strideT'(addr0[13:5] - ipRd.lastLine);
        stride0 = delta;
        if (!ipHit)
        begin
            if (ipRd.valid)
                ipWr.valid = 1'b0;
            else
            begin
                ipWr          = '0;
                ipWr.tag      = ip0[16:8];
                ipWr.lastLine = addr0[13:5];
            end
        end
        else
        begin
            ipWr.valid    = 1'b1;
            ipWr.lastLine = addr0[13:5];
            if (regionHit)
                ipWr.tentative = ~regRd.trained;
            if (regionHit && regRd.trained)
            begin
                ipWr.stream = 1'b1;
                ipWr.dir    = regRd.dir;
            end
            else if (addr0[13:11] != ipRd.lastLine[8:6] && ipRd.tentative)
                ipWr.stream = 1'b0;     // Left the region
            if (ipRd.stream)
            begin
                cls0    = GS;
                stride0 = ipRd.dir ? strideT'(-1) : strideT'(1);
            end
            else
            begin
                if (delta == ipRd.stride && ipRd.conf != 2'd3)
                    ipWr.conf = ipRd.conf + 1'b1;
                else if (delta != ipRd.stride && ipRd.conf != '0)
                    ipWr.conf = ipRd.conf - 1'b1;
                if (ipRd.conf == '0)
                    ipWr.stride = delta;
                if (ipRd.conf[1])
                begin
                    cls0    = CS;
                    stride0 = ipRd.stride;
                end
                else
                    cls0 = CPLX;
            end
        end
    end

    always_comb
    begin
        cls2    = cls1;
        stride2 = stride1;
        csptWr  = csptRd;
        if (cls1 == CPLX)
        begin
            if (csptRd.conf == '0)
            begin
                cls2          = NL;
                csptWr.stride = stride1;
            end
            else
                stride2 = csptRd.stride;
            if (stride1 == csptRd.stride && csptRd.conf != 2'd3)
                csptWr.conf = csptRd.conf + 1'b1;
            else if (stride1 != csptRd.stride && csptRd.conf != '0)
                csptWr.conf = csptRd.conf - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            valid0      <= 1'b0;
            valid1      <= 1'b0;
            classResult <= '0;
        end
        else
        begin
            valid0             <= access.valid;
            valid1             <= valid0;
            classResult.valid  <= valid1;
            classResult.cls    <= cls2;
            classResult.base   <= line1;
            classResult.stride <= stride2;
        end
    end

    always_ff @(posedge clk)
    begin
        ip0     <= access.ip;
        addr0   <= access.addr;
        ipIdx1  <= ip0[7:2];
        line1   <= addr0[31:5];
        cls1    <= cls0;
        stride1 <= stride0;
        sig1    <= csptRaddr;   // Also the CSPT write index
    end

endmodule

//--- logic/strideGenerator.sv
module strideGenerator #(
    parameter int Lead = 1
) (
    input  logic                      clk,
    input  logic                      RST_vout,
    input  ipcpTypesPkg::classResultT classResult,
    output ipcpTypesPkg::prefetchReqT req
);
    import ipcpTypesPkg::*;

    strideT             step;
    logic signed [31:0] jump;

    // Next line always moves one forward
    assign step = (classResult.cls == NL) ? strideT'(1) : classResult.stride;
    assign jump = step * Lead;

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
            req <= '0;
        else
        begin
            // Zero step would just refetch the demand line
            req.valid <= classResult.valid && step != '0;
            req.line  <= classResult.base + lineAddrT'(jump);   // Wraps at 27 bits
        end
    end

endmodule

//--- logic/requestDrain.sv
module requestDrain #(
    parameter int NumGen    = 3,
    parameter int FifoDepth = 8
) (
    input  logic                                   clk,
    input  logic                                   RST_vout,
    input  ipcpTypesPkg::prefetchReqT [NumGen-1:0] reqBundle,
    output ipcpBusPkg::wbMasterT                   wbOut,
    input  ipcpBusPkg::wbSlaveT                    wbIn
);
    import ipcpTypesPkg::*;

    localparam int PtrWidth = $clog2(FifoDepth);

    typedef enum logic
    {
        Idle,
        Busy
    } drainStateT;

    drainStateT          state, stateNext;
    lineAddrT            queue [FifoDepth];
    logic [PtrWidth-1:0] head, tail;
    logic [PtrWidth-1:0] slot [NumGen];
    logic [PtrWidth:0]   fill, fillNext, pushCount;
    logic                accept, pop;

    // Pack valid requests in generator order
    always_comb
    begin
        pushCount = '0;
        for (int k = 0; k < NumGen; k++)
        begin
            slot[k] = tail + pushCount[PtrWidth-1:0];
            if (reqBundle[k].valid)
                pushCount = pushCount + 1'b1;
        end
    end

    assign accept   = pushCount != '0 && (FifoDepth - int'(fill)) >= NumGen;
    assign pop      = state == Busy && wbIn.ack;
    assign fillNext = fill + (accept ? pushCount : '0) - {{PtrWidth{1'b0}}, pop};

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            for (int k = 0; k < NumGen; k++)
            begin
                if (reqBundle[k].valid)
                    queue[slot[k]] <= reqBundle[k].line;
            end
        end
    end

    always_comb
    begin
        stateNext = state;
        case (state)
            Idle:
                if (fillNext != '0)
                    stateNext = Busy;
            Busy:
                if (pop && fillNext == '0)
                    stateNext = Idle;
            default:
                stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!RST_vout)
        begin
            head  <= '0;
            tail  <= '0;
            fill  <= '0;
            state <= Idle;
        end
        else
        begin
            if (accept)
                tail <= tail + pushCount[PtrWidth-1:0];
            if (pop)
                head <= head + 1'b1;
            fill  <= fillNext;
            state <= stateNext;
        end
    end

    // Head stays on the bus until acked
    assign wbOut.cyc = state == Busy;
    assign wbOut.stb = state == Busy;
    assign wbOut.we  = 1'b0;
    assign wbOut.adr = {queue[head], 5'b0};

endmodule

//--- logic/ipcpPrefetch.sv
module ipcpPrefetch #(
    parameter int NumGen    = 3,
    parameter int FifoDepth = 8
) (
    input  logic                 clk,
    input  logic                 RST_vout,
    input  ipcpTypesPkg::accessT access,
    output ipcpBusPkg::wbMasterT wbOut,
    input  ipcpBusPkg::wbSlaveT  wbIn
);
    import ipcpTypesPkg::*;

    classResultT              classResult;
    prefetchReqT [NumGen-1:0] reqBundle;

    ipClassifier uClassifier (
        .clk         (clk),
        .RST_vout    (RST_vout),
        .access      (access),
        .classResult (classResult)
    );

    // Generator k runs k+1 strides ahead
    for (genvar k = 0; k < NumGen; k++)
    begin : genStride
        strideGenerator #(
            .Lead (k + 1)
        ) uGen (
            .clk         (clk),
            .RST_vout    (RST_vout),
            .classResult (classResult),
            .req         (reqBundle[k])
        );
    end

    requestDrain #(
        .NumGen    (NumGen),
        .FifoDepth (FifoDepth)
    ) uDrain (
        .clk       (clk),
        .RST_vout  (RST_vout),
        .reqBundle (reqBundle),
        .wbOut     (wbOut),
        .wbIn      (wbIn)
    );

endmodule

//--- test/ipcpModel.svh
`ifndef IPCP_MODEL_SVH
`define IPCP_MODEL_SVH

typedef prefetchReqT [NumGen-1:0] bundleT;

// IP table and signature mirror, 64 entries
logic [8:0]  ipTag      [64];
logic        ipValid    [64];
logic [8:0]  ipLast     [64];
strideT      ipStride   [64];
confT        ipConf     [64];
logic        ipStream   [64];
logic        ipTent     [64];
logic        ipDir      [64];
logic [6:0]  sigMem     [64];

// Region table mirror, 16 regions of 2 KB
logic [9:0]  regTag     [16];
logic [5:0]  regHits    [16];
logic [5:0]  regLastOff [16];
logic [63:0] regTouched [16];
logic [5:0]  regPosNeg  [16];
logic [5:0]  regDense   [16];
logic        regTrained [16];
logic        regDir     [16];

strideT      csptStride [128];
confT        csptConf   [128];

prefetchClassT modelCls;    // Final class of the last predicted access

initial
begin
    for (int i = 0; i < 128; i++)
    begin
        csptStride[i] = '0;
        csptConf[i]   = '0;
        if (i < 64)
        begin
            {ipTag[i], ipValid[i], ipLast[i], ipStride[i]} = '0;
            {ipConf[i], ipStream[i], ipTent[i], ipDir[i], sigMem[i]} = '0;
        end
        if (i < 16)
        begin
            {regTag[i], regHits[i], regLastOff[i], regTouched[i]} = '0;
            {regPosNeg[i], regDense[i], regTrained[i], regDir[i]} = '0;
        end
    end
end

function automatic bundleT predictBundle(input ipT ip, input byteAddrT addr);
    bundleT        bundle;
    logic [5:0]    ii;
    logic [3:0]    ri;
    logic [5:0]    off;
    logic [5:0]    oldOff;
    logic [5:0]    oldDense;
    logic [8:0]    diff;
    logic [8:0]    oldLast;
    logic [6:0]    sig;
    logic          regHit;
    logic          oldTrained;
    logic          oldRegDir;
    logic          oldStream;
    logic          oldTent;
    logic          oldIpDir;
    confT          oldConf;
    strideT        oldStride;
    strideT        delta;
    strideT        stride;
    strideT        step;
    prefetchClassT cls;

    ii         = ip[7:2];
    ri         = addr[14:11];
    off        = addr[10:5];
    regHit     = regTag[ri] == addr[24:15];
    oldTrained = regTrained[ri];
    oldRegDir  = regDir[ri];
    oldLast    = ipLast[ii];
    diff       = addr[13:5] - oldLast;
    delta      = diff[7:0];     // Stride in lines, 8 bit signed
    cls        = NL;
    stride     = delta;

    if (ipTag[ii] != ip[16:8])
    begin
        if (ipValid[ii])
            ipValid[ii] = 1'b0;
        else
        begin
            {ipValid[ii], ipStride[ii], ipConf[ii]} = '0;
            {ipStream[ii], ipTent[ii], ipDir[ii]} = '0;
            ipTag[ii]  = ip[16:8];
            ipLast[ii] = addr[13:5];
        end
    end
    else
    begin
        oldStream   = ipStream[ii];
        oldIpDir    = ipDir[ii];
        oldTent     = ipTent[ii];
        oldConf     = ipConf[ii];
        oldStride   = ipStride[ii];
        ipValid[ii] = 1'b1;
        ipLast[ii]  = addr[13:5];
        if (regHit)
            ipTent[ii] = ~oldTrained;
        if (regHit && oldTrained)
        begin
            ipStream[ii] = 1'b1;
            ipDir[ii]    = oldRegDir;
        end
        else if (addr[13:11] != oldLast[8:6] && oldTent)
            ipStream[ii] = 1'b0;
        if (oldStream)
        begin
            cls    = GS;
            stride = oldIpDir ? strideT'(-1) : strideT'(1);
        end
        else
        begin
            if (delta == oldStride && oldConf != 2'd3)
                ipConf[ii] = oldConf + 1'b1;
            else if (delta != oldStride && oldConf != 2'd0)
                ipConf[ii] = oldConf - 1'b1;
            if (oldConf == 2'd0)
                ipStride[ii] = delta;
            if (oldConf >= 2'd2)
            begin
                cls    = CS;
                stride = oldStride;
            end
            else
                cls = CPLX;
        end
    end

    oldOff   = regLastOff[ri];
    oldDense = regDense[ri];
    if (!regHit)
    begin
        if (regHits[ri] == 6'd0)
        begin
            {regHits[ri], regTouched[ri], regDense[ri], regTrained[ri]} = '0;
            regTag[ri]     = addr[24:15];
            regLastOff[ri] = off;
            regPosNeg[ri]  = 6'd32;
            regDir[ri]     = 1'b1;
        end
        else
            regHits[ri] = regHits[ri] - 1'b1;
    end
    else
    begin
        if (regHits[ri] != 6'd63)
            regHits[ri] = regHits[ri] + 1'b1;
        regLastOff[ri] = off;
        if (!regTouched[ri][off])
            regDense[ri] = oldDense + 1'b1;
        regTouched[ri][off] = 1'b1;
        if (regPosNeg[ri] != 6'd0 && off < oldOff)
            regPosNeg[ri] = regPosNeg[ri] - 1'b1;
        else if (regPosNeg[ri] != 6'd63 && off > oldOff)
            regPosNeg[ri] = regPosNeg[ri] + 1'b1;
        regTrained[ri] = oldTrained | (oldDense >= 6'd48);
        regDir[ri]     = ~regPosNeg[ri][5];
    end

    // Signature path, only for complex stride candidates
    if (cls == CPLX)
    begin
        sig        = sigMem[ii];
        sigMem[ii] = {sig[5:0], 1'b0} ^ stride[6:0];
        oldStride  = csptStride[sig];
        oldConf    = csptConf[sig];
        if (stride == oldStride && oldConf != 2'd3)
            csptConf[sig] = oldConf + 1'b1;
        else if (stride != oldStride && oldConf != 2'd0)
            csptConf[sig] = oldConf - 1'b1;
        if (oldConf == 2'd0)
        begin
            cls             = NL;
            csptStride[sig] = stride;
        end
        else
            stride = oldStride;
    end

    modelCls = cls;
    step     = (cls == NL) ? strideT'(1) : stride;
    for (int k = 0; k < NumGen; k++)
    begin
        bundle[k].valid = step != 8'sd0;
        bundle[k].line  = addr[31:5] + lineAddrT'(int'(step) * (k + 1));
    end
    return bundle;
endfunction

`endif

//--- test/ipcpPrefetchTb.sv
module ipcpPrefetchTb;
    import ipcpTypesPkg::*;
    import ipcpBusPkg::*;

    localparam int NumGen        = 3;
    localparam int FifoDepth     = 8;
    localparam int CsCount       = 10;
    localparam int GsCount       = 64;
    localparam int CplxCount     = 30;
    localparam int BpCount       = 24;
    localparam int TotalAccesses = CsCount + GsCount + CplxCount + BpCount;
    localparam int TimeoutCycles = TotalAccesses * (NumGen * 4 + 8) + 100;

    logic        clk;
    logic        RST_vout = 1'b0;
    accessT      access   = '0;
    wbMasterT    wbOut;
    wbSlaveT     wbIn     = '0;
    logic [15:0] lfsr     = 16'd39;
    logic        stallOn  = 1'b0;

    `include "ipcpModel.svh"

    bundleT   pendBundle [$];   // Predicted bundles not yet at the drain
    int       pendCycle  [$];
    lineAddrT expLines   [$];
    int       cycleCount    = 0;
    int       occupancy     = 0;
    int       errorCount    = 0;
    int       accessCount   = 0;
    int       transferCount = 0;
    int       dropCount     = 0;
    int       errorMark, accessMark, transferMark, dropMark;
    int       clsSeen [4];

    ipcpPrefetch #(
        .NumGen    (NumGen),
        .FifoDepth (FifoDepth)
    ) dut (
        .clk      (clk),
        .RST_vout (RST_vout),
        .access   (access),
        .wbOut    (wbOut),
        .wbIn     (wbIn)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // Slave acks one cycle after stb, stalls drawn from the LFSR
    always @(posedge clk)
    begin : ackSlave
        logic stall;
        if (!RST_vout)
            wbIn.ack <= 1'b0;
        else if (wbOut.stb && !wbIn.ack)
        begin
            stall = 1'b0;
            if (stallOn)
            begin
                stall = lfsr[0];
                lfsr  = lfsrStep(lfsr);
            end
            wbIn.ack <= !stall;
        end
        else
            wbIn.ack <= 1'b0;
    end

    always @(negedge clk)
    begin : compareBus
        int       free;
        int       count;
        bundleT   bundle;
        wbAddrT   expAdr;
        cycleCount = cycleCount + 1;
        if (RST_vout)
        begin
            free = FifoDepth - occupancy;   // Drain decides on fill before this edge
            if (wbOut.stb && wbIn.ack)
            begin
                assert (expLines.size() != 0)
                else
                begin
                    errorCount++;
                    $display("Read of %h at %0t went out with no request expected",
                             wbOut.adr, $time);
                end
                if (expLines.size() != 0)
                begin
                    expAdr = {expLines.pop_front(), 5'b0};
                    assert (wbOut.adr == expAdr)
                    else
                    begin
                        errorCount++;
                        $display("Error at %0t: wbOut.adr is %h, expected %h",
                                 $time, wbOut.adr, expAdr);
                    end
                    assert (wbOut.cyc && !wbOut.we)
                    else
                    begin
                        errorCount++;
                        $display("Error at %0t: wbOut.cyc/we is %b/%b, expected 1/0",
                                 $time, wbOut.cyc, wbOut.we);
                    end
                    occupancy--;
                    transferCount++;
                end
            end
            if (pendCycle.size() != 0 && pendCycle[0] == cycleCount)
            begin
                bundle = pendBundle.pop_front();
                void'(pendCycle.pop_front());
                count = 0;
                for (int k = 0; k < NumGen; k++)
                    count += bundle[k].valid;
                if (count != 0 && free >= NumGen)
                begin
                    for (int k = 0; k < NumGen; k++)
                    begin
                        if (bundle[k].valid)
                            expLines.push_back(bundle[k].line);
                    end
                    occupancy += count;
                end
                else if (count != 0)
                    dropCount++;    // Whole bundle lost to back-pressure
            end
        end
    end

    task automatic applyAccess(input ipT ip, input byteAddrT addr, input int gap);
        bundleT bundle;
        bundle = predictBundle(ip, addr);
        access <= {1'b1, ip, addr};
        pendBundle.push_back(bundle);
        pendCycle.push_back(cycleCount + 5);    // Edge at which the drain sees it
        clsSeen[modelCls]++;
        accessCount++;
        @(posedge clk);
        access.valid <= 1'b0;
        repeat (gap) @(posedge clk);
    endtask

    task automatic waitDrained();
        while (pendCycle.size() != 0 || expLines.size() != 0 || wbOut.stb)
            @(posedge clk);
    endtask

    task automatic beginTest();
        errorMark    = errorCount;
        accessMark   = accessCount;
        transferMark = transferCount;
        dropMark     = dropCount;
        for (int c = 0; c < 4; c++)
            clsSeen[c] = 0;
    endtask

    task automatic requireClass(input prefetchClassT cls, input string what);
        assert (clsSeen[cls] > 0)
        else
        begin
            errorCount++;
            $display("The %s test never produced a %s prediction", what, cls.name());
        end
    endtask

    task automatic reportTest(input int num, input string what);
        $display("Test %0d %s: %0d accesses, %0d transfers, %0d dropped, %0d errors",
                 num, what, accessCount - accessMark, transferCount - transferMark,
                 dropCount - dropMark, errorCount - errorMark);
    endtask

    initial
    begin
        int offset;
        repeat (4) @(posedge clk);
        RST_vout <= 1'b1;

        beginTest();
        repeat (10)
        begin
            @(posedge clk);
            assert (!wbOut.cyc && !wbOut.stb)
            else
            begin
                errorCount++;
                $display("Error at %0t: wbOut.cyc/stb is %b/%b, expected 0/0",
                         $time, wbOut.cyc, wbOut.stb);
            end
        end
        reportTest(1, "after reset");

        beginTest();
        for (int i = 0; i < CsCount; i++)
        begin
            applyAccess(32'h0000_1A44, 32'h0010_0000 + i * 3 * 32, 2);
            waitDrained();
        end
        requireClass(CS, "constant stride");
        reportTest(2, "constant stride");

        // Four IPs sweep one region downwards
        beginTest();
        for (int i = 0; i < GsCount; i++)
        begin
            applyAccess(32'h0000_2200 + 4 * (i % 4), 32'h0040_1800 + (63 - i) * 32, 2);
            waitDrained();
        end
        requireClass(GS, "global stream");
        reportTest(3, "global stream");

        beginTest();
        offset = 0;
        for (int i = 0; i < CplxCount; i++)
        begin
            applyAccess(32'h0000_3330, 32'h0080_3000 + offset * 32, 2);
            waitDrained();
            offset += (i % 3 == 0) ? 1 : (i % 3 == 1) ? 3 : -2;
        end
        requireClass(CPLX, "complex stride");
        reportTest(4, "complex stride");

        beginTest();
        stallOn <= 1'b1;
        for (int i = 0; i < BpCount; i++)
            applyAccess(32'h0000_4450, 32'h0100_5000 + i * 2 * 32, 2);
        waitDrained();
        stallOn <= 1'b0;
        assert (dropCount > dropMark)
        else
        begin
            errorCount++;
            $display("Back-pressure test never filled the queue enough to drop a bundle");
        end
        reportTest(5, "back-pressure");

        $display("Accesses %0d, transfers %0d, dropped bundles %0d, errors %0d",
                 accessCount, transferCount, dropCount, errorCount);
        if (errorCount == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        int cycles;
        cycles = 0;
        while (cycles < TimeoutCycles)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the prefetch stream did not drain", cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- ipcpPrefetch.f
logic/ipcpTypesPkg.sv
logic/ipcpBusPkg.sv
logic/tableRam.sv
logic/ipClassifier.sv
logic/strideGenerator.sv
logic/requestDrain.sv
logic/ipcpPrefetch.sv
+incdir+test
test/ipcpPrefetchTb.sv
